// File: src.f
src/cdcPkg.sv
src/cdcRegisters.sv
src/sectorLoader.sv
src/sectorDma.sv
src/bufferArbiter.sv
src/cdSubsystem.sv
sim/cdSubsystem_checker.sv
sim/cdSubsystemTb.sv

// File: Makefile
# Verilator build and run of the CD data path testbench
VERILATOR ?= verilator
TOP       ?= cdSubsystemTb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only -Wall --timing --timescale $(TIMESCALE)
PASS_TEXT ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the testbench prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/cdSubsystemTb.sv
/*
 * Testbench for the CD data path.
 * A table of CPU register accesses, sector feeds, interrupt checks and
 * DMA runs is applied in order. Sector bytes are random and kept in a
 * model that header reads and host bytes are compared against.
 */
`default_nettype none

module cdSubsystemTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int bufferAddrBits = 11;
	localparam int sectorBytes = 64;   // Same as the top-level default
	localparam int totalBytes = cdcPkg::headerBytes + sectorBytes;
	localparam int opBound = 400;      // Cycles any single step may need
	localparam int irqWait = 200;

	typedef enum logic [3:0] {
		opSetAddr, opWrite, opReadAddr, opRead, opReadModel,
		opFeed, opIrqLow, opIrqHigh, opDma
	} opKind;

	typedef struct packed {
		opKind op;
		logic [15:0] arg;                      // Data, expected byte or DMA start
		logic [cdcPkg::countWidth-1:0] cnt;    // DMA byte count minus one
	} step;

	logic clk_sys = 1'b0;
	logic nRESET, cpuClkEn, nWr, nRd, rs, discStrobe;
	logic [7:0] din, discByte;
	wire [7:0] dout, hostData;
	wire cdcNIrq, hostStrobe;

	step steps[$];
	logic [7:0] sectorModel [totalBytes];   // Header then payload
	logic [7:0] hostQ[$];                   // Bytes seen on the host side
	int stepNo, checks, valueErrors, otherErrors;
	bit tableReady = 1'b0;

	always #2 clk_sys = ~clk_sys;   // 4 ns period

	cdSubsystem #(.bufferAddrBits(bufferAddrBits), .sectorBytes(sectorBytes)) cdSubsystem_i (
		.clk_sys(clk_sys), .nRESET(nRESET), .cpuClkEn(cpuClkEn), .nWr(nWr), .nRd(nRd),
		.rs(rs), .din(din), .dout(dout), .cdcNIrq(cdcNIrq), .discStrobe(discStrobe),
		.discByte(discByte), .hostStrobe(hostStrobe), .hostData(hostData)
	);

	bind cdSubsystem cdSubsystem_checker cdSubsystemChecker_i (
		.clk_sys(clk_sys), .nRESET(nRESET), .cdcNIrq(cdcNIrq), .hostStrobe(hostStrobe),
		.dmaRunning(dmaRunning), .rdGrant(rdGrant), .wrReq(wrReq)
	);

	// Host side capture, away from the active edge
	always @(negedge clk_sys)
		if (hostStrobe)
			hostQ.push_back(hostData);

	// ==============================
	// Bus and disc tasks
	// ==============================
	task automatic addStep(input opKind op, input logic [15:0] arg,
		input logic [cdcPkg::countWidth-1:0] cnt);
		step s;
		s.op = op;
		s.arg = arg;
		s.cnt = cnt;
		steps.push_back(s);
	endtask

	task automatic busWrite(input logic sel, input logic [7:0] data);
		@(posedge clk_sys);
		rs <= sel;
		din <= data;
		nWr <= 1'b0;
		repeat (4) @(posedge clk_sys);   // Edge is seen two cycles in
		nWr <= 1'b1;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic busRead(input logic sel, input logic [7:0] expected);
		@(posedge clk_sys);
		rs <= sel;
		nRd <= 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);              // dout settled one cycle after the edge
		checks++;
		assert (dout === expected)
		else
		begin
			valueErrors++;
			$display("error dout at step %0d: got %h, expected %h", stepNo, dout, expected);
		end
		@(posedge clk_sys);
		nRd <= 1'b1;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic feedSector();
		foreach (sectorModel[i])
			sectorModel[i] = 8'($urandom);
		for (int i = 0; i < totalBytes; i++)
		begin
			@(posedge clk_sys);
			discStrobe <= 1'b1;
			discByte <= sectorModel[i];
			@(posedge clk_sys);
			discStrobe <= 1'b0;   // Every other cycle at most
		end
	endtask

	task automatic waitIrqLow();
		int waited;
		waited = 0;
		while (cdcNIrq !== 1'b0 && waited < irqWait)
		begin
			@(negedge clk_sys);
			waited++;
		end
		checks++;
		assert (cdcNIrq === 1'b0)
		else
		begin
			otherErrors++;
			$display("interrupt did not arrive within %0d cycles at step %0d", irqWait, stepNo);
		end
	endtask

	task automatic checkIrqHigh();
		repeat (3) @(negedge clk_sys);   // Line is registered after the flags
		checks++;
		assert (cdcNIrq === 1'b1)
		else
		begin
			valueErrors++;
			$display("error cdcNIrq at step %0d: got %h, expected 1", stepNo, cdcNIrq);
		end
	endtask

	// Programs DBC and DAC from DBCL upward, then triggers through DTTRG
	task automatic runDma(input logic [15:0] first, input logic [cdcPkg::countWidth-1:0] cnt);
		int waited;
		int expectCount;
		expectCount = int'(cnt) + 1;
		busWrite(1'b0, 8'(cdcPkg::regDbcl));
		busWrite(1'b1, cnt[7:0]);
		busWrite(1'b1, {4'h0, cnt[cdcPkg::countWidth-1:8]});
		busWrite(1'b1, first[7:0]);
		busWrite(1'b1, first[15:8]);
		hostQ.delete();
		busWrite(1'b1, 8'h00);   // DTTRG
		waited = 0;
		while (hostQ.size() < expectCount && waited < opBound)
		begin
			@(negedge clk_sys);
			waited++;
		end
		repeat (8) @(negedge clk_sys);   // Room for any extra strobe
		checks++;
		assert (hostQ.size() == expectCount)
		else
		begin
			otherErrors++;
			$display("host got %0d bytes instead of %0d at step %0d",
				hostQ.size(), expectCount, stepNo);
		end
		for (int i = 0; i < hostQ.size() && i < expectCount; i++)
		begin
			checks++;
			assert (hostQ[i] === sectorModel[cdcPkg::headerBytes + int'(first) + i])
			else
			begin
				valueErrors++;
				$display("error hostData byte %0d: got %h, expected %h", i, hostQ[i],
					sectorModel[cdcPkg::headerBytes + int'(first) + i]);
			end
		end
	endtask

	task automatic applyStep(input step s);
		case (s.op)
			opSetAddr: busWrite(1'b0, s.arg[7:0]);
			opWrite: busWrite(1'b1, s.arg[7:0]);
			opReadAddr: busRead(1'b0, s.arg[7:0]);
			opRead: busRead(1'b1, s.arg[7:0]);
			opReadModel: busRead(1'b1, sectorModel[s.arg]);   // Header byte from the model
			opFeed: feedSector();
			opIrqLow: waitIrqLow();
			opIrqHigh: checkIrqHigh();
			default: runDma(s.arg, s.cnt);
		endcase
	endtask

	// ==============================
	// Stimulus table
	// ==============================
	task automatic buildTable();
		addStep(opIrqHigh, 16'h0000, '0);
		addStep(opSetAddr, 16'h0007, '0);   // Address register readback
		addStep(opReadAddr, 16'h0007, '0);
		addStep(opSetAddr, 16'(cdcPkg::regDbcl), '0);
		addStep(opWrite, 16'h005a, '0);
		addStep(opWrite, 16'h0003, '0);
		addStep(opSetAddr, 16'(cdcPkg::regDbcl), '0);
		addStep(opRead, 16'h005a, '0);
		addStep(opRead, 16'h0003, '0);      // Flag nibble still clear
		addStep(opSetAddr, 16'(cdcPkg::regWalPtl), '0);
		addStep(opWrite, 16'h0034, '0);
		addStep(opWrite, 16'h0012, '0);     // Now pointing at WAL readback
		addStep(opRead, 16'h0034, '0);
		addStep(opRead, 16'h0012, '0);
		addStep(opRead, 16'(cdcPkg::stat0Value), '0);
		addStep(opSetAddr, 16'(cdcPkg::regWalPtl), '0);
		addStep(opRead, 16'(cdcPkg::ptLowValue), '0);
		addStep(opRead, 16'h0000, '0);
		// Decoder interrupt on a fed sector
		addStep(opSetAddr, 16'(cdcPkg::regCtrl0Wal), '0);
		addStep(opWrite, 16'h0080, '0);     // DECEN
		addStep(opSetAddr, 16'(cdcPkg::regIfctrlIfstat), '0);
		addStep(opWrite, 16'h0020, '0);     // Decoder interrupt enable
		addStep(opIrqHigh, 16'h0000, '0);
		addStep(opFeed, 16'h0000, '0);
		addStep(opIrqLow, 16'h0000, '0);
		addStep(opSetAddr, 16'(cdcPkg::regDaclHead0), '0);
		for (int i = 0; i < cdcPkg::headerBytes; i++)
			addStep(opReadModel, 16'(i), '0);
		addStep(opSetAddr, 16'(cdcPkg::regStat3), '0);
		addStep(opRead, 16'h0000, '0);      // Valid bit low
		addStep(opIrqHigh, 16'h0000, '0);
		// Transfers with the end interrupt masked
		addStep(opDma, 16'h0005, 12'd20);
		addStep(opDma, 16'(sectorBytes - 1), 12'd0);
		addStep(opIrqHigh, 16'h0000, '0);
		// Transfer end interrupt
		addStep(opSetAddr, 16'(cdcPkg::regDtackHead3), '0);
		addStep(opWrite, 16'h0000, '0);
		addStep(opSetAddr, 16'(cdcPkg::regIfctrlIfstat), '0);
		addStep(opWrite, 16'h0060, '0);
		addStep(opIrqHigh, 16'h0000, '0);
		addStep(opDma, 16'h0020, 12'd31);
		addStep(opIrqLow, 16'h0000, '0);
		addStep(opSetAddr, 16'(cdcPkg::regIfctrlIfstat), '0);
		addStep(opRead, 16'h00bf, '0);      // Transfer end flag shows as zero
		addStep(opRead, 16'h001f, '0);
		addStep(opRead, 16'h00f0, '0);
		addStep(opSetAddr, 16'(cdcPkg::regDtackHead3), '0);
		addStep(opWrite, 16'h0000, '0);
		addStep(opIrqHigh, 16'h0000, '0);
	endtask

	// ==============================
	// Run and watchdog
	// ==============================
	initial
	begin
		nRESET = 1'b1;   // Falls on the first rising edge
		cpuClkEn = 1'b1;
		nWr = 1'b1;
		nRd = 1'b1;
		rs = 1'b0;
		din = 8'h00;
		discStrobe = 1'b0;
		discByte = 8'h00;
		void'($urandom(32'hfd131a13));
		buildTable();
		tableReady = 1'b1;
		@(posedge clk_sys);
		nRESET <= 1'b0;
		repeat (16) @(posedge clk_sys);
		nRESET <= 1'b1;
		repeat (4) @(posedge clk_sys);
		for (stepNo = 0; stepNo < steps.size(); stepNo++)
			applyStep(steps[stepNo]);
		$display("checks %0d, value errors %0d, other errors %0d",
			checks, valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial
	begin
		wait (tableReady);
		repeat (20 + steps.size() * opBound) @(posedge clk_sys);
		$display("watchdog expired, the step table did not finish in time");
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/cdSubsystem_checker.sv
/*
 * Concurrent assertions on the CD data path top level.
 * Bound into cdSubsystem by the testbench, it watches the interrupt
 * line in reset, the host strobe against the DMA busy level and the
 * buffer arbitration between loader and DMA engine.
 */
`default_nettype none

module cdSubsystem_checker
(
	input wire clk_sys,
	input wire nRESET,
	input wire cdcNIrq,
	input wire hostStrobe,
	input wire dmaRunning,
	input wire rdGrant,
	input wire wrReq
);
	timeunit 1ns;
	timeprecision 100ps;

	// Interrupt line idles high while reset is held
	irqHighInReset: assert property (@(posedge clk_sys) !nRESET |-> cdcNIrq)
		else $error("cdcNIrq low while nRESET is asserted");

	// Host bytes only leave during a transfer
	strobeInTransfer: assert property (@(posedge clk_sys) disable iff (!nRESET)
		hostStrobe |-> dmaRunning)
		else $error("hostStrobe seen while dmaRunning is low");

	// Loader owns the buffer port whenever it asks
	grantExclusive: assert property (@(posedge clk_sys) disable iff (!nRESET)
		!(rdGrant && wrReq))
		else $error("read grant given in a loader write cycle");

endmodule

`default_nettype wire

// File: src/cdSubsystem.sv
/*
 * Top level of the CD data path.
 * The CPU programs the host controller registers, the loader fills the
 * sector buffer from the disc stream and the DMA engine moves a byte
 * range from the buffer to the host. Buffer size and sector length are
 * set here and passed down.
 */
`default_nettype none

module cdSubsystem
#(
	parameter int bufferAddrBits = 11,
	parameter int sectorBytes = 64
)
(
	input  wire        clk_sys,
	input  wire        nRESET,
	input  wire        cpuClkEn,
	input  wire        nWr,
	input  wire        nRd,
	input  wire        rs,
	input  wire  [7:0] din,
	output logic [7:0] dout,
	output logic       cdcNIrq,
	input  wire        discStrobe,
	input  wire  [7:0] discByte,
	output logic       hostStrobe,
	output logic [7:0] hostData
);

	// Loader to controller
	logic headerWr, headerSel, sectorReady;
	logic [15:0] headerWord;
	// Controller and DMA engine
	logic dmaStart, dmaRunning;
	logic [cdcPkg::countWidth-1:0] dbc;
	logic [15:0] dac;
	// Buffer ports
	logic wrReq, rdReq, rdGrant;
	logic [bufferAddrBits-1:0] wrAddr, rdAddr;
	logic [7:0] wrData, rdData;

	cdcRegisters cdcRegisters_i (
		.clk_sys(clk_sys), .nRESET(nRESET), .cpuClkEn(cpuClkEn),
		.nWr(nWr), .nRd(nRd), .rs(rs), .din(din), .dout(dout),
		.headerWr(headerWr), .headerSel(headerSel), .headerWord(headerWord),
		.sectorReady(sectorReady), .dmaRunning(dmaRunning),
		.dmaStart(dmaStart), .dbc(dbc), .dac(dac), .cdcNIrq(cdcNIrq)
	);

	sectorLoader #(.bufferAddrBits(bufferAddrBits), .sectorBytes(sectorBytes)) sectorLoader_i (
		.clk_sys(clk_sys), .nRESET(nRESET), .discStrobe(discStrobe), .discByte(discByte),
		.headerWr(headerWr), .headerSel(headerSel), .headerWord(headerWord),
		.wrReq(wrReq), .wrAddr(wrAddr), .wrData(wrData), .sectorReady(sectorReady)
	);

	sectorDma #(.bufferAddrBits(bufferAddrBits)) sectorDma_i (
		.clk_sys(clk_sys), .nRESET(nRESET), .dmaStart(dmaStart), .dbc(dbc), .dac(dac),
		.rdReq(rdReq), .rdAddr(rdAddr), .rdGrant(rdGrant), .rdData(rdData),
		.dmaRunning(dmaRunning), .hostStrobe(hostStrobe), .hostData(hostData)
	);

	bufferArbiter #(.bufferAddrBits(bufferAddrBits)) bufferArbiter_i (
		.clk_sys(clk_sys), .wrReq(wrReq), .wrAddr(wrAddr), .wrData(wrData),
		.rdReq(rdReq), .rdAddr(rdAddr), .rdGrant(rdGrant), .rdData(rdData)
	);

endmodule

`default_nettype wire

// File: src/bufferArbiter.sv
/*
 * Sector buffer shared by the loader and the DMA engine.
 * A single-port byte RAM serves one access per cycle. Loader writes
 * always win and complete in the cycle they are requested; a DMA read
 * is granted only in a free cycle and its data is registered, so it
 * shows on rdData the cycle after rdGrant.
 */
`default_nettype none

module bufferArbiter
#(
	parameter int bufferAddrBits = 11
)
(
	input  wire                       clk_sys,
	input  wire                       wrReq,     // Loader, never stalled
	input  wire  [bufferAddrBits-1:0] wrAddr,
	input  wire                 [7:0] wrData,
	input  wire                       rdReq,     // DMA engine
	input  wire  [bufferAddrBits-1:0] rdAddr,
	output logic                      rdGrant,
	output logic                [7:0] rdData
);

	// ==============================
	// Port ownership
	// ==============================
	logic [7:0] ram [2**bufferAddrBits];
	logic [bufferAddrBits-1:0] ramAddr;   // Address of the single port

	// Loader first, DMA takes what is left
	assign rdGrant = rdReq & ~wrReq;
	assign ramAddr = wrReq ? wrAddr : rdAddr;

	// ==============================
	// RAM
	// ==============================
	always_ff @(posedge clk_sys)
	begin
		if (wrReq)
			ram[ramAddr] <= wrData;
		else if (rdGrant)
			rdData <= ram[ramAddr];   // Held between reads
	end

endmodule

`default_nettype wire

// File: src/sectorDma.sv
/*
 * DMA engine from the sector buffer to the host.
 * dmaStart loads dbc+1 bytes starting at dac. Reads are requested one
 * per cycle while granted, so several can be in flight, and every
 * returned byte leaves on hostData with a hostStrobe. dmaRunning falls
 * with the last strobe.
 */
`default_nettype none

module sectorDma
#(
	parameter int bufferAddrBits = 11
)
(
	input  wire                          clk_sys,
	input  wire                          nRESET,
	input  wire                          dmaStart,
	input  wire [cdcPkg::countWidth-1:0] dbc,       // Bytes to move minus one
	input  wire                   [15:0] dac,       // First buffer address
	output logic                         rdReq,
	output logic    [bufferAddrBits-1:0] rdAddr,
	input  wire                          rdGrant,
	input  wire                    [7:0] rdData,
	output logic                         dmaRunning,
	output logic                         hostStrobe,
	output logic                   [7:0] hostData
);

	localparam logic [cdcPkg::countWidth:0] lastOne = {{cdcPkg::countWidth{1'b0}}, 1'b1};

	logic [cdcPkg::countWidth:0] reqLeft;   // Reads not yet granted
	logic [cdcPkg::countWidth:0] retLeft;   // Bytes not yet handed to the host

	assign rdReq = reqLeft != '0;
	assign hostData = rdData;   // Buffer read data is already registered

	// ==============================
	// Counters and status
	// ==============================
	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			reqLeft <= '0;
			retLeft <= '0;
			dmaRunning <= 1'b0;
			hostStrobe <= 1'b0;
		end
		else
		begin
			hostStrobe <= rdGrant;   // Data returns one cycle after the grant
			if (dmaStart)
			begin
				reqLeft <= {1'b0, dbc} + 1'b1;
				retLeft <= {1'b0, dbc} + 1'b1;
				dmaRunning <= 1'b1;
			end
			else
			begin
				if (rdGrant)
					reqLeft <= reqLeft - 1'b1;
				if (hostStrobe)
				begin
					retLeft <= retLeft - 1'b1;
					if (retLeft == lastOne)
						dmaRunning <= 1'b0;   // Last byte is on hostData now
				end
			end
		end
	end

	// Read address walks up on each grant
	always_ff @(posedge clk_sys)
	begin
		if (dmaStart)
			rdAddr <= dac[bufferAddrBits-1:0];
		else if (rdGrant)
			rdAddr <= rdAddr + 1'b1;
	end

endmodule

`default_nettype wire

// File: src/sectorLoader.sv
/*
 * Splits the disc byte stream into header words and buffer writes.
 * The first bytes of each sector pair into header words for the host
 * controller, the payload goes to the sector buffer from address 0.
 * sectorReady holds high from the last payload byte to the next sector.
 */
`default_nettype none

module sectorLoader
#(
	parameter int bufferAddrBits = 11,
	parameter int sectorBytes = 64
)
(
	input  wire                       clk_sys,
	input  wire                       nRESET,
	input  wire                       discStrobe,   // One cycle per disc byte
	input  wire                 [7:0] discByte,
	output logic                      headerWr,
	output logic                      headerSel,
	output logic               [15:0] headerWord,
	output logic                      wrReq,
	output logic [bufferAddrBits-1:0] wrAddr,
	output logic                [7:0] wrData,
	output logic                      sectorReady
);

	localparam int totalBytes = cdcPkg::headerBytes + sectorBytes;
	localparam int countBits = $clog2(totalBytes);

	logic [countBits-1:0] byteCount;   // Position within the sector
	logic [7:0] headerLow;             // Even header byte waiting for its pair
	logic inHeader, lastByte;

	assign inHeader = byteCount < countBits'(cdcPkg::headerBytes);
	assign lastByte = byteCount == countBits'(totalBytes - 1);

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			byteCount <= '0;
			headerWr <= 1'b0;
			wrReq <= 1'b0;
			sectorReady <= 1'b0;
		end
		else
		begin
			headerWr <= 1'b0;
			wrReq <= 1'b0;
			if (discStrobe)
			begin
				byteCount <= lastByte ? '0 : byteCount + 1'b1;
				if (inHeader)
					headerWr <= byteCount[0];   // Odd byte completes a word
				else
					wrReq <= 1'b1;
				if (byteCount == '0)
					sectorReady <= 1'b0;        // New sector begins
				else if (lastByte)
					sectorReady <= 1'b1;
			end
		end
	end

	// Word and buffer payload
	always_ff @(posedge clk_sys)
	begin
		if (discStrobe)
		begin
			if (inHeader)
			begin
				if (byteCount[0])
				begin
					headerWord <= {discByte, headerLow};   // Lower index in low half
					headerSel <= byteCount[1];
				end
				else
					headerLow <= discByte;
			end
			else
			begin
				wrAddr <= bufferAddrBits'(byteCount - countBits'(cdcPkg::headerBytes));
				wrData <= discByte;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/cdcRegisters.sv
/*
 * CPU-side register model of the CD host controller.
 * With rs low the CPU accesses the address register, with rs high the
 * register it points at, and a nonzero address then auto-increments.
 * Disc side header words and the sector-ready level, plus the DMA busy
 * level, drive the interrupt flags. Writing DTTRG pulses dmaStart.
 */
`default_nettype none

module cdcRegisters
(
	input  wire         clk_sys,
	input  wire         nRESET,
	input  wire         cpuClkEn,     // CPU bus clock enable
	input  wire         nWr,
	input  wire         nRd,
	input  wire         rs,           // Low selects the address register
	input  wire   [7:0] din,
	output logic  [7:0] dout,
	input  wire         headerWr,     // One pulse per header word
	input  wire         headerSel,    // High for header bytes 2 and 3
	input  wire  [15:0] headerWord,
	input  wire         sectorReady,
	input  wire         dmaRunning,
	output logic        dmaStart,
	output logic [cdcPkg::countWidth-1:0] dbc,
	output logic [15:0] dac,
	output logic        cdcNIrq
);

	logic [3:0] addrReg;            // Register pointer
	logic [15:0] wa;                // Write address, only read back
	logic dteIen, decIen;           // IFCTRL interrupt enables
	logic decEn;                    // CTRL0 decoder enable
	logic dteiFlag, deciFlag;
	logic nValSt;                   // Low once a decoded header is valid
	logic [7:0] headTemp [4];       // Header being assembled
	logic [7:0] head [4];           // Header as the CPU sees it

	// CPU strobes, two stages on the enabled clock
	logic nWrQ, nWrPrev;
	logic nRdQ, nRdPrev;
	logic sectorReadyPrev, dmaRunningPrev;
	logic wrEdge, rdEdge, readyRise, dmaFall;

	assign wrEdge = nWrPrev & ~nWrQ;
	assign rdEdge = nRdPrev & ~nRdQ;
	assign readyRise = sectorReady & ~sectorReadyPrev & decEn;   // Only counts while decoding
	assign dmaFall = dmaRunningPrev & ~dmaRunning;

	// ==============================
	// Header capture
	// ==============================
	always_ff @(posedge clk_sys)
	begin
		if (headerWr)
		begin
			if (headerSel)
			begin
				headTemp[2] <= headerWord[7:0];
				headTemp[3] <= headerWord[15:8];   // Mode byte
			end
			else
			begin
				headTemp[0] <= headerWord[7:0];    // Minute
				headTemp[1] <= headerWord[15:8];   // Second
			end
		end
	end

	// ==============================
	// Register access and flags
	// ==============================
	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			addrReg <= 4'd0;
			dout <= 8'h00;
			dmaStart <= 1'b0;
			dbc <= '0;
			dac <= 16'h0000;
			wa <= 16'h0000;
			{dteIen, decIen} <= 2'b00;
			decEn <= 1'b0;
			{dteiFlag, deciFlag} <= 2'b00;
			nValSt <= 1'b1;
			head <= '{default: 8'h00};
			nWrQ <= 1'b1;
			nWrPrev <= 1'b1;
			nRdQ <= 1'b1;
			nRdPrev <= 1'b1;
			sectorReadyPrev <= 1'b0;
			dmaRunningPrev <= 1'b0;
			cdcNIrq <= 1'b1;
		end
		else
		begin
			dmaStart <= 1'b0;   // Single cycle pulse
			sectorReadyPrev <= sectorReady;
			dmaRunningPrev <= dmaRunning;
			cdcNIrq <= ~|{dteiFlag & dteIen, deciFlag & decIen};

			if (cpuClkEn)
			begin
				nWrQ <= nWr;
				nWrPrev <= nWrQ;
				nRdQ <= nRd;
				nRdPrev <= nRdQ;

				if (wrEdge)
				begin
					if (!rs)
						addrReg <= din[3:0];
					else
					begin
						case (addrReg)
							cdcPkg::regIfctrlIfstat: {dteIen, decIen} <= din[6:5];
							cdcPkg::regDbcl: dbc[7:0] <= din;
							cdcPkg::regDbch: dbc[cdcPkg::countWidth-1:8] <= din[cdcPkg::countWidth-9:0];
							cdcPkg::regDaclHead0: dac[7:0] <= din;
							cdcPkg::regDachHead1: dac[15:8] <= din;
							cdcPkg::regDttrgHead2: dmaStart <= 1'b1;
							cdcPkg::regDtackHead3: dteiFlag <= 1'b0;
							cdcPkg::regWalPtl: wa[7:0] <= din;
							cdcPkg::regWahPth: wa[15:8] <= din;
							cdcPkg::regCtrl0Wal: decEn <= din[7];
							default: ;   // COMIN, CTRL1, PT and RESET have no effect here
						endcase
						if (addrReg != 4'd0)
							addrReg <= addrReg + 4'd1;
					end
				end
				else if (rdEdge)
				begin
					if (!rs)
						dout <= {4'b0000, addrReg};
					else
					begin
						case (addrReg)
							cdcPkg::regCominSbout: dout <= 8'h00;   // No status bytes queued
							// Command interrupt and the busy and enable bits all idle high
							cdcPkg::regIfctrlIfstat: dout <= {1'b1, ~dteiFlag, ~deciFlag, 5'b11111};
							cdcPkg::regDbcl: dout <= dbc[7:0];
							cdcPkg::regDbch: dout <= {{4{dteiFlag}}, dbc[cdcPkg::countWidth-1:8]};
							cdcPkg::regDaclHead0: dout <= head[0];
							cdcPkg::regDachHead1: dout <= head[1];
							cdcPkg::regDttrgHead2: dout <= head[2];
							cdcPkg::regDtackHead3: dout <= head[3];
							cdcPkg::regWalPtl: dout <= cdcPkg::ptLowValue;
							cdcPkg::regWahPth: dout <= 8'h00;
							cdcPkg::regCtrl0Wal: dout <= wa[7:0];
							cdcPkg::regCtrl1Wah: dout <= wa[15:8];
							cdcPkg::regStat0: dout <= cdcPkg::stat0Value;
							cdcPkg::regStat3:
							begin
								dout <= {nValSt, 7'b0000000};
								deciFlag <= 1'b0;    // Read acknowledges the decoder interrupt
								nValSt <= 1'b1;
							end
							default: dout <= 8'h00;  // STAT1 no errors, STAT2 Mode 1
						endcase
						if (addrReg != 4'd0)
							addrReg <= addrReg + 4'd1;
					end
				end
			end

			// Disc and DMA events come last so a same-cycle clear cannot lose them
			if (dmaFall)
				dteiFlag <= 1'b1;
			if (readyRise)
			begin
				deciFlag <= 1'b1;
				nValSt <= 1'b0;
				head <= headTemp;   // Publish the finished header
			end
		end
	end

endmodule

`default_nettype wire

// File: src/cdcPkg.sv
/*
 * Shared definitions for the CD data path model.
 * Holds the host controller register map, the fixed status bytes and
 * the widths that several blocks agree on. Blocks refer to these by
 * scoped name.
 */
`default_nettype none

package cdcPkg;

	// ==============================
	// Register map
	// ==============================
	// Paired names give the write meaning first, then the read meaning
	typedef enum logic [3:0] {
		regCominSbout   = 4'd0,
		regIfctrlIfstat = 4'd1,
		regDbcl         = 4'd2,   // Byte counter low
		regDbch         = 4'd3,   // Byte counter high
		regDaclHead0    = 4'd4,
		regDachHead1    = 4'd5,
		regDttrgHead2   = 4'd6,   // Write starts a transfer
		regDtackHead3   = 4'd7,   // Write acknowledges transfer end
		regWalPtl       = 4'd8,
		regWahPth       = 4'd9,
		regCtrl0Wal     = 4'd10,
		regCtrl1Wah     = 4'd11,
		regStat0        = 4'd12,
		regStat1        = 4'd13,
		regStat2        = 4'd14,
		regStat3        = 4'd15
	} regIndex;

	// ==============================
	// Fixed values
	// ==============================
	localparam logic [7:0] ptLowValue = 8'h04;   // Data block starts past the header
	localparam logic [7:0] stat0Value = 8'h80;   // CRC good
	localparam int headerBytes = 4;               // Minute, second, frame, mode
	localparam int countWidth = 12;               // DBC width

endpackage

`default_nettype wire
